// File: bench/bootLoaderTb.sv
// Directed testbench for the boot loader.
// Flash and RAM are modelled as ACK_n responders. The boot runs once with
// and once without the cartridge ROM clear, and the RAM is checked after.

`default_nettype none

module bootLoaderTb
    import bootPkg::*;
;
    localparam int clockPeriod = 4;
    localparam int resetCycles = 5;
    localparam int ackDelay = 2;
    localparam int quietCycles = 100;
    localparam logic [31:0] lfsrSeed = 32'd83300;
    localparam logic [31:0] lfsrTaps = 32'h80200003;
    localparam logic [7:0] presetByte = 8'h5A;
    localparam int ramDepth = 1 << ramAddrWidth;
    localparam int biosBytes = int'(biosSize);
    localparam int totalBytes = int'(biosSize) + int'(megaromSize) + int'(mapperSize);
    // Two runs with twice the bytes times 12 cycles for each
    localparam int timeLimit = 2 * (2 * totalBytes * 12 + 500) * clockPeriod;

    logic CLK;
    logic RESET_n;
    logic clearMegarom;
    logic ready;
    logic memoryHold;
    logic ledOn;
    logic flashEnable_n;
    logic flashReq_n;
    logic [flashAddrWidth-1:0] flashAddress;
    logic flashAck_n;
    logic [7:0] flashData;
    logic [ramAddrWidth-1:0] ramAddr;
    logic [7:0] ramDin;
    logic ramWe_n;
    logic ramRfsh_n;
    logic ramAck_n;

    logic [7:0] flashImage [biosBytes];
    logic [7:0] ramMem [ramDepth];
    int refreshCount;
    int byteErrors;
    int addrErrors;
    int bitErrors;
    int countErrors;

    bootLoader dut (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .clearMegarom  (clearMegarom),
        .ready         (ready),
        .memoryHold    (memoryHold),
        .ledOn         (ledOn),
        .flashEnable_n (flashEnable_n),
        .flashReq_n    (flashReq_n),
        .flashAddress  (flashAddress),
        .flashAck_n    (flashAck_n),
        .flashData     (flashData),
        .ramAddr       (ramAddr),
        .ramDin        (ramDin),
        .ramWe_n       (ramWe_n),
        .ramRfsh_n     (ramRfsh_n),
        .ramAck_n      (ramAck_n)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(clockPeriod / 2) CLK = ~CLK;
    end

    // ------------------------------
    // Memory models
    // ------------------------------
    // Flash answers enable once and then one byte per request
    initial
    begin
        logic opened;
        logic [flashAddrWidth-1:0] readPtr;
        int index;
        flashAck_n = 1'b1;
        flashData = 8'h00;
        opened = 1'b0;
        readPtr = '0;
        forever
        begin
            @(posedge CLK);
            if (flashEnable_n || !RESET_n)
                opened = 1'b0;
            else if (!opened)
            begin
                repeat (ackDelay) @(posedge CLK);
                checkFlashAddr("flashAddress", flashAddress, biosSrcAddr);
                readPtr = flashAddress;
                opened = 1'b1;
                flashAck_n <= 1'b0;
                @(posedge CLK);
                flashAck_n <= 1'b1;
            end
            else if (!flashReq_n)
            begin
                repeat (ackDelay) @(posedge CLK);
                index = int'(readPtr) - int'(biosSrcAddr);
                flashData <= (index >= 0 && index < biosBytes) ? flashImage[index] : 8'h00;
                readPtr = readPtr + 1'b1;
                flashAck_n <= 1'b0;
                do @(posedge CLK); while (!flashReq_n);
                flashAck_n <= 1'b1;
            end
        end
    end

    // RAM shares one ACK_n between write and refresh
    initial
    begin
        ramAck_n = 1'b1;
        forever
        begin
            @(posedge CLK);
            if (RESET_n && (!ramWe_n || !ramRfsh_n))
            begin
                if (!ramWe_n)
                    ramMem[ramAddr] = ramDin;
                else
                    refreshCount++;
                repeat (ackDelay) @(posedge CLK);
                ramAck_n <= 1'b0;
                do @(posedge CLK); while (!ramWe_n || !ramRfsh_n);
                ramAck_n <= 1'b1;
            end
        end
    end

    initial
    begin
        #(timeLimit);
        $display("Timeout: the boot did not reach ready in the allowed time");
        $display("Checks failed");
        $finish;
    end

    // ------------------------------
    // Helpers and compare tasks
    // ------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        lfsrStep = s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    function automatic int ceilDiv(input int num, input int den);
        ceilDiv = (num + den - 1) / den;
    endfunction

    task automatic buildFlashImage();
        logic [31:0] lfsr;
        logic [7:0] value;
        lfsr = lfsrSeed;
        for (int i = 0; i < biosBytes; i++)
        begin
            value = 8'h00;
            // One step per bit taken
            repeat (8)
            begin
                lfsr = lfsrStep(lfsr);
                value = {value[6:0], lfsr[0]};
            end
            flashImage[i] = value;
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            byteErrors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input logic [ramAddrWidth-1:0] got,
                             input logic [ramAddrWidth-1:0] exp);
        if (got !== exp)
        begin
            addrErrors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlashAddr(input string name, input logic [flashAddrWidth-1:0] got,
                                  input logic [flashAddrWidth-1:0] exp);
        if (got !== exp)
        begin
            addrErrors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            bitErrors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp)
        begin
            countErrors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic inspectResetState();
        checkBit("ready", ready, 1'b0);
        checkBit("memoryHold", memoryHold, 1'b1);
        checkBit("ledOn", ledOn, 1'b1);
        checkBit("flashEnable_n", flashEnable_n, 1'b1);
        checkBit("flashReq_n", flashReq_n, 1'b1);
        checkBit("ramWe_n", ramWe_n, 1'b1);
        checkBit("ramRfsh_n", ramRfsh_n, 1'b1);
    endtask

    // RAM preset and then reset held for resetCycles with clearMegarom set up
    task automatic resetDut(input logic clear);
        for (int a = 0; a < ramDepth; a++)
            ramMem[a] = presetByte;
        refreshCount = 0;
        @(posedge CLK);
        RESET_n <= 1'b0;
        clearMegarom <= clear;
        repeat (resetCycles - 1) @(posedge CLK);
        @(negedge CLK);
        inspectResetState();
        @(posedge CLK);
        RESET_n <= 1'b1;
        // First edge that the DUT runs out of reset
        @(posedge CLK);
        @(negedge CLK);
        inspectResetState();
    endtask

    task automatic awaitReady();
        while (ready !== 1'b1)
            @(negedge CLK);
    endtask

    task automatic watchAfterReady();
        checkBit("memoryHold", memoryHold, 1'b0);
        checkBit("ledOn", ledOn, 1'b0);
        checkBit("flashEnable_n", flashEnable_n, 1'b1);
        // Writer address ends one past the mapper region
        checkAddr("ramAddr", ramAddr, ramAddrWidth'(int'(mapperAddr) + int'(mapperSize)));
        repeat (quietCycles)
        begin
            @(negedge CLK);
            checkBit("ready", ready, 1'b1);
            checkBit("memoryHold", memoryHold, 1'b0);
            checkBit("ledOn", ledOn, 1'b0);
            checkBit("flashEnable_n", flashEnable_n, 1'b1);
            checkBit("ramWe_n", ramWe_n, 1'b1);
            checkBit("ramRfsh_n", ramRfsh_n, 1'b1);
        end
    endtask

    task automatic tallyRefreshes(input logic clear);
        int expected;
        expected = ceilDiv(int'(biosSize), int'(refreshPeriod));
        if (clear)
            expected += ceilDiv(int'(megaromSize), int'(refreshPeriod));
        expected += ceilDiv(int'(mapperSize), int'(refreshPeriod));
        checkCount("refresh handshakes", refreshCount, expected);
    endtask

    task automatic scanRam(input logic clear);
        logic [7:0] expected;
        int biosLo;
        int megaLo;
        int mapLo;
        biosLo = int'(biosDstAddr);
        megaLo = int'(megaromAddr);
        mapLo = int'(mapperAddr);
        for (int a = 0; a < ramDepth; a++)
        begin
            if (a >= biosLo && a < biosLo + biosBytes)
                expected = flashImage[a - biosLo];
            else if (clear && a >= megaLo && a < megaLo + int'(megaromSize))
                expected = megaromFill;
            else if (a >= mapLo && a < mapLo + int'(mapperSize))
                expected = mapperFill;
            else
                expected = presetByte;
            checkByte($sformatf("ram[%05h]", a), ramMem[a], expected);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic testWithClear();
        resetDut(1'b1);
        awaitReady();
        watchAfterReady();
        tallyRefreshes(1'b1);
        scanRam(1'b1);
    endtask

    task automatic testWithoutClear();
        resetDut(1'b0);
        awaitReady();
        watchAfterReady();
        tallyRefreshes(1'b0);
        scanRam(1'b0);
    endtask

    initial
    begin
        RESET_n = 1'b0;
        clearMegarom = 1'b0;
        refreshCount = 0;
        byteErrors = 0;
        addrErrors = 0;
        bitErrors = 0;
        countErrors = 0;
        buildFlashImage();
        testWithClear();
        testWithoutClear();
        $display("Error counts: byte %0d, address %0d, bit %0d, count %0d",
                 byteErrors, addrErrors, bitErrors, countErrors);
        if (byteErrors + addrErrors + bitErrors + countErrors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bootLoader.f
rtl/bootPkg.sv
rtl/ramWriteIf.sv
rtl/flashReadIf.sv
rtl/bootControl.sv
rtl/flashReader.sv
rtl/ramWriter.sv
rtl/refreshScheduler.sv
rtl/bootLoader.sv
bench/bootLoaderTb.sv

// File: rtl/bootControl.sv
// Job sequencer of the boot loader.
// Runs the BIOS copy, the optional cartridge ROM clear and the mapper
// clear one byte at a time, then releases the system.

`default_nettype none

module bootControl
    import bootPkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    input  logic clearMegarom,
    output logic ready,
    output logic memoryHold,
    output logic ledOn,
    flashReadIf.ctrl flash,
    ramWriteIf.ctrl ram,
    output logic refreshRestart,
    output logic refreshCheck,
    input  logic refreshDone
);

    typedef enum logic [1:0] {jobBios, jobMegarom, jobMapper} job_e;
    typedef enum logic [2:0] {
        stLoad, stOpen, stNext, stRead, stRefresh, stWrite, stDone
    } state_e;

    state_e state;
    job_e job;
    jobArg_u jobArg;

    assign flash.arg = jobArg;
    // Copy takes the flash byte and fills take the byte from the argument
    assign ram.wrData = (job == jobBios) ? flash.rdData : jobArg.fill.fillByte;

    // Region and argument of the job about to start
    always_ff @(posedge CLK)
    begin
        if (state == stLoad)
        begin
            case (job)
                jobBios:
                begin
                    ram.base <= biosDstAddr;
                    ram.size <= biosSize;
                    jobArg.flashAddr <= biosSrcAddr;
                end
                jobMegarom:
                begin
                    ram.base <= megaromAddr;
                    ram.size <= megaromSize;
                    jobArg.fill.pad <= '0;
                    jobArg.fill.fillByte <= megaromFill;
                end
                default:
                begin
                    ram.base <= mapperAddr;
                    ram.size <= mapperSize;
                    jobArg.fill.pad <= '0;
                    jobArg.fill.fillByte <= mapperFill;
                end
            endcase
        end
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= stLoad;
            job <= jobBios;
            ready <= 1'b0;
            memoryHold <= 1'b1;
            ledOn <= 1'b1;
            ram.load <= 1'b0;
            ram.write <= 1'b0;
            flash.open <= 1'b0;
            flash.close <= 1'b0;
            flash.read <= 1'b0;
            refreshRestart <= 1'b0;
            refreshCheck <= 1'b0;
        end
        else
        begin
            // Strobes last one cycle
            ram.load <= 1'b0;
            ram.write <= 1'b0;
            flash.open <= 1'b0;
            flash.close <= 1'b0;
            flash.read <= 1'b0;
            refreshRestart <= 1'b0;
            refreshCheck <= 1'b0;

            case (state)
                stLoad:
                begin
                    ram.load <= 1'b1;
                    refreshRestart <= 1'b1;
                    flash.open <= (job == jobBios);
                    state <= stOpen;
                end
                // Fill jobs pass straight through, giving the writer a cycle to load
                stOpen:
                begin
                    if (job != jobBios || flash.opDone)
                        state <= stNext;
                end
                // ------------------------------
                // Per-byte steps
                // ------------------------------
                stNext:
                begin
                    if (ram.empty)
                    begin
                        case (job)
                            jobBios:
                            begin
                                flash.close <= 1'b1;
                                job <= clearMegarom ? jobMegarom : jobMapper;
                                state <= stLoad;
                            end
                            jobMegarom:
                            begin
                                job <= jobMapper;
                                state <= stLoad;
                            end
                            default:
                                state <= stDone;
                        endcase
                    end
                    else if (job == jobBios)
                    begin
                        flash.read <= 1'b1;
                        state <= stRead;
                    end
                    else
                    begin
                        refreshCheck <= 1'b1;
                        state <= stRefresh;
                    end
                end
                stRead:
                begin
                    if (flash.opDone)
                    begin
                        refreshCheck <= 1'b1;
                        state <= stRefresh;
                    end
                end
                stRefresh:
                begin
                    if (refreshDone)
                    begin
                        ram.write <= 1'b1;
                        state <= stWrite;
                    end
                end
                stWrite:
                begin
                    if (ram.wrDone)
                        state <= stNext;
                end
                stDone:
                begin
                    ready <= 1'b1;
                    memoryHold <= 1'b0;
                    ledOn <= 1'b0;
                end
                default:
                    state <= stLoad;
            endcase
        end
    end

    // Completions only arrive while the FSM waits for them
    assert property (@(posedge CLK) disable iff (!RESET_n)
        ram.wrDone |-> state == stWrite);

    assert property (@(posedge CLK) disable iff (!RESET_n)
        refreshDone |-> state == stRefresh);

endmodule

`default_nettype wire

// File: rtl/bootLoader.sv
// Top level of the boot loader.
// Copies the BIOS from flash to RAM, clears the RAM regions and raises
// ready. Flash and RAM use strobe and ACK_n handshakes.

`default_nettype none

module bootLoader
    import bootPkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    input  logic clearMegarom,
    output logic ready,
    output logic memoryHold,
    output logic ledOn,
    output logic flashEnable_n,
    output logic flashReq_n,
    output logic [flashAddrWidth-1:0] flashAddress,
    input  logic flashAck_n,
    input  logic [7:0] flashData,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic [7:0] ramDin,
    output logic ramWe_n,
    output logic ramRfsh_n,
    input  logic ramAck_n
);

    ramWriteIf ramBus ();
    flashReadIf flashBus ();

    logic refreshRestart;
    logic refreshCheck;
    logic refreshDone;

    bootControl control (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .clearMegarom   (clearMegarom),
        .ready          (ready),
        .memoryHold     (memoryHold),
        .ledOn          (ledOn),
        .flash          (flashBus.ctrl),
        .ram            (ramBus.ctrl),
        .refreshRestart (refreshRestart),
        .refreshCheck   (refreshCheck),
        .refreshDone    (refreshDone)
    );

    flashReader reader (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .ctrl          (flashBus.reader),
        .flashEnable_n (flashEnable_n),
        .flashReq_n    (flashReq_n),
        .flashAddress  (flashAddress),
        .flashAck_n    (flashAck_n),
        .flashData     (flashData)
    );

    ramWriter writer (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .ctrl     (ramBus.writer),
        .ramAddr  (ramAddr),
        .ramDin   (ramDin),
        .ramWe_n  (ramWe_n),
        .ramAck_n (ramAck_n)
    );

    // Write strobe goes in as well for the overlap check
    refreshScheduler refresh (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .refreshRestart (refreshRestart),
        .refreshCheck   (refreshCheck),
        .refreshDone    (refreshDone),
        .ramRfsh_n      (ramRfsh_n),
        .ramAck_n       (ramAck_n),
        .ramWe_n        (ramWe_n)
    );

endmodule

`default_nettype wire

// File: rtl/bootPkg.sv
// Shared definitions for the boot loader.
// Holds the bus widths, the fixed job table with fill bytes and the
// refresh period. Modules take it by a wildcard import.

`default_nettype none

package bootPkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned ramAddrWidth = 18;
    localparam int unsigned ramCountWidth = 17;
    localparam int unsigned flashAddrWidth = 24;

    // ------------------------------
    // Job table
    // ------------------------------
    // BIOS copy from flash
    localparam logic [ramAddrWidth-1:0] biosDstAddr = 18'h00000;
    localparam logic [ramCountWidth-1:0] biosSize = 17'd32768;
    localparam logic [flashAddrWidth-1:0] biosSrcAddr = 24'h100000;

    // Cartridge ROM clear, only when requested
    localparam logic [ramAddrWidth-1:0] megaromAddr = 18'h10000;
    localparam logic [ramCountWidth-1:0] megaromSize = 17'd32768;
    localparam logic [7:0] megaromFill = 8'hFF;

    // Memory mapper clear
    localparam logic [ramAddrWidth-1:0] mapperAddr = 18'h20000;
    localparam logic [ramCountWidth-1:0] mapperSize = 17'd65536;
    localparam logic [7:0] mapperFill = 8'h00;

    // One refresh every this many writes
    localparam int unsigned refreshPeriod = 512;
    localparam int unsigned refreshCountWidth = 9;

    // Argument of the current job, a flash address or a fill byte
    typedef union packed {
        logic [flashAddrWidth-1:0] flashAddr;
        struct packed {
            logic [15:0] pad;
            logic [7:0] fillByte;
        } fill;
    } jobArg_u;

endpackage

`default_nettype wire

// File: rtl/flashReadIf.sv
// Link from the control FSM to the flash reader.
// open and read each end with one opDone pulse; close has no answer.
// rdData holds the last byte read until the next read.

`default_nettype none

interface flashReadIf
    import bootPkg::*;
();
    logic open;
    logic close;
    jobArg_u arg;
    logic read;
    logic opDone;
    logic [7:0] rdData;

    modport ctrl (output open, close, arg, read, input opDone, rdData);
    modport reader (input open, close, arg, read, output opDone, rdData);
endinterface

`default_nettype wire

// File: rtl/flashReader.sv
// Flash side of the boot loader.
// open latches the source address and holds enable low until close;
// each read runs one request handshake and keeps the returned byte.

`default_nettype none

module flashReader
    import bootPkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    flashReadIf.reader ctrl,
    output logic flashEnable_n,
    output logic flashReq_n,
    output logic [flashAddrWidth-1:0] flashAddress,
    input  logic flashAck_n,
    input  logic [7:0] flashData
);

    typedef enum logic [1:0] {stIdle, stWaitAck, stWaitRelease} state_e;

    state_e state;

    // Address and data only
    always_ff @(posedge CLK)
    begin
        if (state == stIdle && ctrl.open)
            flashAddress <= ctrl.arg.flashAddr;
        // Byte is valid while ACK_n is low on a read
        if (state == stWaitAck && !flashAck_n && !flashReq_n)
            ctrl.rdData <= flashData;
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= stIdle;
            flashEnable_n <= 1'b1;
            flashReq_n <= 1'b1;
            ctrl.opDone <= 1'b0;
        end
        else
        begin
            ctrl.opDone <= 1'b0;
            case (state)
                stIdle:
                begin
                    if (ctrl.close)
                        flashEnable_n <= 1'b1;
                    if (ctrl.open)
                    begin
                        flashEnable_n <= 1'b0;
                        state <= stWaitAck;
                    end
                    else if (ctrl.read)
                    begin
                        flashReq_n <= 1'b0;
                        state <= stWaitAck;
                    end
                end
                // Enable stays low here, only the request drops
                stWaitAck:
                begin
                    if (!flashAck_n)
                    begin
                        flashReq_n <= 1'b1;
                        state <= stWaitRelease;
                    end
                end
                stWaitRelease:
                begin
                    if (flashAck_n)
                    begin
                        ctrl.opDone <= 1'b1;
                        state <= stIdle;
                    end
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (!RESET_n)
        !flashReq_n |-> !flashEnable_n);

endmodule

`default_nettype wire

// File: rtl/ramWriteIf.sv
// Link from the control FSM to the RAM writer.
// ctrl loads a region and strobes one write per byte; the writer
// reports when the region is used up and when each write is done.

`default_nettype none

interface ramWriteIf
    import bootPkg::*;
();
    logic load;
    logic [ramAddrWidth-1:0] base;
    logic [ramCountWidth-1:0] size;
    logic [7:0] wrData;
    logic write;
    logic empty;
    logic wrDone;

    modport ctrl (output load, base, size, wrData, write, input empty, wrDone);
    modport writer (input load, base, size, wrData, write, output empty, wrDone);
endinterface

`default_nettype wire

// File: rtl/ramWriter.sv
// RAM write side of the boot loader.
// Keeps the running address and the bytes left in the region, and
// runs one write handshake per write strobe.

`default_nettype none

module ramWriter
    import bootPkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    ramWriteIf.writer ctrl,
    output logic [ramAddrWidth-1:0] ramAddr,
    output logic [7:0] ramDin,
    output logic ramWe_n,
    input  logic ramAck_n
);

    typedef enum logic [1:0] {stIdle, stWaitAck, stWaitRelease} state_e;

    state_e state;
    logic [ramAddrWidth-1:0] addr;
    logic [ramCountWidth-1:0] remaining;

    assign ramAddr = addr;
    assign ctrl.empty = (remaining == '0);

    // Address and data path
    always_ff @(posedge CLK)
    begin
        if (ctrl.load)
            addr <= ctrl.base;
        else if (state == stWaitRelease && ramAck_n)
            addr <= addr + 1'b1;
        if (state == stIdle && ctrl.write)
            ramDin <= ctrl.wrData;
    end

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= stIdle;
            remaining <= '0;
            ramWe_n <= 1'b1;
            ctrl.wrDone <= 1'b0;
        end
        else
        begin
            ctrl.wrDone <= 1'b0;
            if (ctrl.load)
                remaining <= ctrl.size;
            case (state)
                stIdle:
                begin
                    if (ctrl.write)
                    begin
                        ramWe_n <= 1'b0;
                        state <= stWaitAck;
                    end
                end
                stWaitAck:
                begin
                    if (!ramAck_n)
                    begin
                        ramWe_n <= 1'b1;
                        state <= stWaitRelease;
                    end
                end
                // Count drops with the done pulse so empty is current
                stWaitRelease:
                begin
                    if (ramAck_n)
                    begin
                        remaining <= remaining - 1'b1;
                        ctrl.wrDone <= 1'b1;
                        state <= stIdle;
                    end
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (!RESET_n)
        ctrl.write |-> !ctrl.empty && state == stIdle);

endmodule

`default_nettype wire

// File: rtl/refreshScheduler.sv
// RAM refresh pacing for the boot loader.
// Counts refresh checks and runs a refresh handshake on the first check
// of a job and on every refreshPeriod-th check after it.

`default_nettype none

module refreshScheduler
    import bootPkg::*;
(
    input  logic CLK,
    input  logic RESET_n,
    input  logic refreshRestart,
    input  logic refreshCheck,
    output logic refreshDone,
    output logic ramRfsh_n,
    input  logic ramAck_n,
    input  logic ramWe_n
);

    typedef enum logic [1:0] {stIdle, stWaitAck, stWaitRelease} state_e;

    state_e state;
    logic [refreshCountWidth-1:0] count;

    always_ff @(posedge CLK or negedge RESET_n)
    begin
        if (!RESET_n)
        begin
            state <= stIdle;
            count <= '0;
            ramRfsh_n <= 1'b1;
            refreshDone <= 1'b0;
        end
        else
        begin
            refreshDone <= 1'b0;
            case (state)
                stIdle:
                begin
                    if (refreshRestart)
                        count <= '0;
                    else if (refreshCheck)
                    begin
                        count <= (count == refreshCountWidth'(refreshPeriod - 1)) ?
                                 '0 : count + 1'b1;
                        // Refresh due on a wrap to zero
                        if (count == '0)
                        begin
                            ramRfsh_n <= 1'b0;
                            state <= stWaitAck;
                        end
                        else
                            refreshDone <= 1'b1;
                    end
                end
                stWaitAck:
                begin
                    if (!ramAck_n)
                    begin
                        ramRfsh_n <= 1'b1;
                        state <= stWaitRelease;
                    end
                end
                stWaitRelease:
                begin
                    if (ramAck_n)
                    begin
                        refreshDone <= 1'b1;
                        state <= stIdle;
                    end
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    // Refresh and write share the RAM, never both at once
    assert property (@(posedge CLK) disable iff (!RESET_n)
        !(!ramRfsh_n && !ramWe_n));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the boot loader testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert -f bootLoader.f \
        --top-module bootLoaderTb --Mdir "$buildDir" -o bootLoaderSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! "./$buildDir/bootLoaderSim" > "$logFile" 2>&1; then
    cat "$logFile"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$logFile"
if grep -qx "All checks passed" "$logFile"; then
    exit 0
fi
exit 1
